// ==== Makefile ====
.PHONY: sim clean

sim:
	rm -f sim.log
	verilator --binary --timing -Wno-fatal --top-module bchDecoderTb \
		-f bchDecoder.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bchDecoder.f ====
+incdir+test
design/bchPkg.sv
design/gfMultiplier.sv
design/syndromeCalc.sv
design/errorLocator.sv
design/decoderCtrl.sv
design/errorCorrector.sv
design/bchDecoder.sv
test/bchDecoderTb.sv

// ==== design/bchDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module bchDecoder (
	input wire logic clk,
	input wire logic rst,
	input wire logic dataIn,
	input wire logic dataValid,
	input wire logic dataFirst,
	output wire logic ready,
	output wire bchPkg::corrOut out
);
	import bchPkg::*;

	wire logic bitEn;
	wire logic frameEnd;
	wire locStrobes strobes;
	wire gfElem syn1;
	wire synWindow window;
	wire gfPoly locPoly;

	decoderCtrl uCtrl (
		.clk(clk),
		.rst(rst),
		.dataValid(dataValid),
		.dataFirst(dataFirst),
		.ready(ready),
		.bitEn(bitEn),
		.frameEnd(frameEnd),
		.strobes(strobes)
	);

	syndromeCalc uSyn (
		.clk(clk),
		.rst(rst),
		.dataIn(dataIn),
		.bitEn(bitEn),
		.frameEnd(frameEnd),
		.strobes(strobes),
		.syn1(syn1),
		.window(window)
	);

	errorLocator uLoc (
		.clk(clk),
		.rst(rst),
		.strobes(strobes),
		.syn1(syn1),
		.window(window),
		.drnzero(),
		.cNout(locPoly)
	);

	errorCorrector uCorr (
		.clk(clk),
		.rst(rst),
		.dataIn(dataIn),
		.bitEn(bitEn),
		.frameEnd(frameEnd),
		.chStart(strobes.ch_start),
		.locator(locPoly),
		.out(out)
	);
endmodule

`default_nettype wire

// ==== design/bchPkg.sv ====
`default_nettype none

package bchPkg;
	localparam int M = 4; // field degree
	localparam int T = 3; // correctable errors
	localparam int N = (1 << M) - 1;
	localparam int SYN_CNT = 2 * T - 1; // syndromes the locator consumes

	// primitive polynomial of the field, bit M included
	function automatic logic [M:0] primPoly(input int m);
		case (m)
			3: return (M + 1)'('b1011);
			5: return (M + 1)'('b100101);
			6: return (M + 1)'('b1000011);
			7: return (M + 1)'('b10001001);
			8: return (M + 1)'('b100011101);
			default: return (M + 1)'('b10011);
		endcase
	endfunction

	localparam logic [M:0] POLY = primPoly(M);

	typedef logic [M-1:0] gfElem;
	typedef gfElem [T:0] gfPoly; // element 0 is the constant term
	typedef gfElem [SYN_CNT-1:0] synWindow;
	typedef logic [$clog2(N + 1)-1:0] bitCount;

	// alpha raised to e, reduced by POLY
	function automatic gfElem alphaPow(input int e);
		logic [M:0] r;
		r = (M + 1)'(1);
		for (int i = 0; i < e; i++) begin
			r = r << 1;
			if (r[M])
				r = r ^ POLY;
		end
		return r[M-1:0];
	endfunction

	typedef struct packed {
		logic synpe; // locator init
		logic snce; // polynomial update
		logic bsel; // correction branch enable
		logic msmpe; // discrepancy latch
		logic ch_start; // locator to chien search
	} locStrobes;

	typedef struct packed {
		logic dataBit;
		logic valid;
		logic first;
		logic last;
		logic fail; // qualified by last
	} corrOut;

	typedef enum logic [2:0] {
		IDLE,
		COLLECT,
		LOAD,
		ITERATE,
		HANDOFF
	} ctrlState;
endpackage

`default_nettype wire

// ==== design/decoderCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoderCtrl (
	input wire logic clk,
	input wire logic rst,
	input wire logic dataValid,
	input wire logic dataFirst,
	output logic ready,
	output logic bitEn,
	output logic frameEnd,
	output bchPkg::locStrobes strobes
);
	import bchPkg::*;

	ctrlState state;
	bitCount bitCnt; // accepted bits of the current frame
	bitCount iterCnt;
	logic phase; // second half of an iteration

	assign ready = (state == IDLE) || (state == COLLECT);
	assign bitEn = dataValid && ((state == COLLECT) || ((state == IDLE) && dataFirst));
	assign frameEnd = bitEn && (bitCnt == bitCount'(N - 1));

	always_comb begin
		strobes.synpe = (state == LOAD);
		strobes.msmpe = (state == ITERATE) && !phase;
		strobes.snce = (state == ITERATE) && phase;
		strobes.bsel = phase;
		strobes.ch_start = (state == HANDOFF);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			bitCnt <= '0;
			iterCnt <= '0;
			phase <= 1'b0;
		end else begin
			case (state)
				IDLE, COLLECT: begin
					if (frameEnd) begin
						bitCnt <= '0;
						state <= LOAD;
					end else if (bitEn) begin
						bitCnt <= bitCnt + 1'b1;
						state <= COLLECT;
					end
				end
				LOAD: begin
					iterCnt <= '0;
					phase <= 1'b0;
					state <= ITERATE;
				end
				ITERATE: begin
					phase <= !phase;
					if (phase) begin
						iterCnt <= iterCnt + 1'b1;
						if (iterCnt == bitCount'(T - 1))
							state <= HANDOFF; // all T double cycles done
					end
				end
				HANDOFF: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end
endmodule

`default_nettype wire

// ==== design/errorCorrector.sv ====
`timescale 1ns/1ps
`default_nettype none

module errorCorrector (
	input wire logic clk,
	input wire logic rst,
	input wire logic dataIn,
	input wire logic bitEn,
	input wire logic frameEnd,
	input wire logic chStart,
	input wire bchPkg::gfPoly locator,
	output bchPkg::corrOut out
);
	import bchPkg::*;

	logic [1:0][N-1:0] frameBuf; // double buffer, one frame per half
	logic wrSel;
	logic rdSel;
	logic rdActive;
	bitCount wrPos;
	bitCount rdPos;
	bitCount rootCnt;
	bitCount locDeg;
	bitCount degNext;
	gfPoly chien;
	gfElem chienSum;
	logic isRoot;
	logic lastBit;

	wire gfPoly chienNext;

	for (genvar i = 0; i <= T; i++) begin : gChien
		gfMultiplier #(
			.ROWS(1)
		) uStep (
			.a(alphaPow(i)),
			.row(chien[i]),
			.prod(chienNext[i])
		);
	end

	always_comb begin
		chienSum = '0;
		for (int i = 0; i <= T; i++)
			chienSum = chienSum ^ chienNext[i];
	end

	always_comb begin
		degNext = '0;
		for (int i = 1; i <= T; i++)
			if (locator[i] != '0)
				degNext = bitCount'(i);
	end

	always_ff @(posedge clk) begin
		if (bitEn)
			frameBuf[wrSel][wrPos] <= dataIn;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrSel <= 1'b0;
			wrPos <= '0;
		end else if (frameEnd) begin
			wrSel <= !wrSel;
			wrPos <= '0;
		end else if (bitEn) begin
			wrPos <= wrPos + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rdActive <= 1'b0;
			rdSel <= 1'b0;
			rdPos <= '0;
			rootCnt <= '0;
		end else if (chStart) begin
			rdActive <= 1'b1;
			rdSel <= !wrSel; // the half that was just filled
			rdPos <= '0;
			rootCnt <= '0;
		end else if (rdActive) begin
			rdPos <= rdPos + 1'b1;
			rootCnt <= rootCnt + bitCount'(isRoot);
			if (lastBit)
				rdActive <= 1'b0;
		end
	end

	// output bit k is evaluated at alpha^(k+1)
	always_ff @(posedge clk) begin
		if (chStart) begin
			chien <= locator;
			locDeg <= degNext;
		end else if (rdActive) begin
			chien <= chienNext;
		end
	end

	assign isRoot = (chienSum == '0);
	assign lastBit = rdActive && (rdPos == bitCount'(N - 1));

	always_comb begin
		out.dataBit = frameBuf[rdSel][rdPos] ^ isRoot;
		out.valid = rdActive;
		out.first = rdActive && (rdPos == '0);
		out.last = lastBit;
		out.fail = lastBit && ((rootCnt + bitCount'(isRoot)) != locDeg); // root count vs degree
	end
endmodule

`default_nettype wire

// ==== design/errorLocator.sv ====
`timescale 1ns/1ps
`default_nettype none

module errorLocator (
	input wire logic clk,
	input wire logic rst,
	input wire bchPkg::locStrobes strobes,
	input wire bchPkg::gfElem syn1,
	input wire bchPkg::synWindow window,
	output logic drnzero,
	output bchPkg::gfPoly cNout // locator polynomial
);
	import bchPkg::*;

	gfElem dr; // current discrepancy
	gfElem dp; // last nonzero discrepancy
	gfPoly dN; // correction polynomial, kept multiplied by x
	gfElem drSum;
	logic signed [$clog2(2 * T + 2):0] lenGap; // iteration index minus register length
	logic takeBranch;

	wire gfPoly sProd; // C(i) * S terms of the discrepancy
	wire gfPoly gC; // dp * C
	wire gfPoly dD; // dr * correction polynomial

	for (genvar i = 0; i <= T; i++) begin : gCoef
		gfMultiplier #(
			.ROWS(2)
		) uCoef (
			.a(cNout[i]),
			.row({window[i], dp}),
			.prod({sProd[i], gC[i]})
		);
	end

	gfMultiplier #(
		.ROWS(T + 1)
	) uCorr (
		.a(dr),
		.row(dN),
		.prod(dD)
	);

	always_comb begin
		drSum = '0;
		for (int i = 0; i <= T; i++)
			drSum = drSum ^ sProd[i];
	end

	assign drnzero = strobes.synpe ? (syn1 != '0) : (dr != '0);
	// length change only when the register is not already too long
	assign takeBranch = strobes.bsel && drnzero && (lenGap >= 0);

	always_ff @(posedge clk) begin
		if (rst) begin
			cNout <= '0;
			dN <= '0;
			dr <= '0;
			dp <= '0;
			lenGap <= '0;
		end else if (strobes.synpe) begin
			cNout <= gfPoly'(1); // C = 1
			dN <= gfPoly'(1) << M; // x * B with B = 1
			dr <= syn1;
			dp <= gfElem'(1);
			lenGap <= '0;
		end else begin
			if (strobes.msmpe)
				dr <= drSum;
			if (strobes.snce) begin
				cNout <= gC ^ dD; // inversionless update
				if (takeBranch) begin
					dN <= cNout << (2 * M); // x^2 * C
					dp <= dr;
					lenGap <= -lenGap;
				end else begin
					dN <= dN << (2 * M);
					lenGap <= lenGap + 1'b1;
				end
			end
		end
	end
endmodule

`default_nettype wire

// ==== design/gfMultiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module gfMultiplier #(
	parameter int ROWS = 1
) (
	input wire bchPkg::gfElem a,
	input wire bchPkg::gfElem [ROWS-1:0] row,
	output bchPkg::gfElem [ROWS-1:0] prod
);
	import bchPkg::*;

	// shift-and-add, reducing after every shift
	function automatic gfElem gfMul(input gfElem x, input gfElem y);
		logic [M:0] p;
		p = '0;
		for (int i = M - 1; i >= 0; i--) begin
			p = p << 1;
			if (p[M])
				p = p ^ POLY;
			if (y[i])
				p = p ^ {1'b0, x};
		end
		return p[M-1:0];
	endfunction

	always_comb begin
		for (int r = 0; r < ROWS; r++)
			prod[r] = gfMul(a, row[r]);
	end
endmodule

`default_nettype wire

// ==== design/syndromeCalc.sv ====
`timescale 1ns/1ps
`default_nettype none

module syndromeCalc (
	input wire logic clk,
	input wire logic rst,
	input wire logic dataIn,
	input wire logic bitEn,
	input wire logic frameEnd, // last accepted bit of the frame
	input wire bchPkg::locStrobes strobes,
	output bchPkg::gfElem syn1,
	output bchPkg::synWindow window
);
	import bchPkg::*;

	gfElem [SYN_CNT-1:0] acc; // acc[j] holds S(j+1)
	wire gfElem [SYN_CNT-1:0] accScaled;
	wire gfElem [SYN_CNT-1:0] accNext;

	// horner step: acc * alpha^(j+1) + bit
	for (genvar j = 0; j < SYN_CNT; j++) begin : gHorner
		gfMultiplier #(
			.ROWS(1)
		) uStep (
			.a(alphaPow(j + 1)),
			.row(acc[j]),
			.prod(accScaled[j])
		);
		assign accNext[j] = accScaled[j] ^ gfElem'(dataIn);
	end

	always_ff @(posedge clk) begin
		if (rst)
			acc <= '0;
		else if (frameEnd)
			acc <= '0; // ready for the next frame
		else if (bitEn)
			acc <= accNext;
	end

	// window order makes iteration k see S(2k+1) down to S(2k+1-T)
	// after rotating by two on each snce
	always_ff @(posedge clk) begin
		if (frameEnd) begin
			window[0] <= accNext[0];
			for (int i = 1; i < SYN_CNT; i++)
				window[i] <= accNext[SYN_CNT - i];
		end else if (strobes.snce) begin
			window <= {window[SYN_CNT-3:0], window[SYN_CNT-1:SYN_CNT-2]};
		end
	end

	assign syn1 = window[0]; // S1 while the locator initialises
endmodule

`default_nettype wire

// ==== test/bchModel.svh ====
`ifndef BCH_MODEL_SVH
`define BCH_MODEL_SVH

localparam logic [M:0] FIELD_POLY = 5'b10011; // x^4 + x + 1

// multiply by walking the bits of y and doubling x
function automatic gfElem fieldMul(input gfElem x, input gfElem y);
	logic [M:0] shifted;
	gfElem prod;
	shifted = {1'b0, x};
	prod = '0;
	for (int i = 0; i < M; i++) begin
		if (y[i])
			prod = prod ^ shifted[M-1:0];
		shifted = shifted << 1;
		if (shifted[M])
			shifted = shifted ^ FIELD_POLY;
	end
	return prod;
endfunction

// product of (x + alpha^e) over the cyclotomic cosets of alpha^1 .. alpha^2T
task automatic buildGenerator(output logic [N:0] gen, output int deg);
	gfElem coef [N+1];
	gfElem root;
	bit inSet [N];
	int e;
	for (int i = 0; i < N; i++)
		inSet[i] = 1'b0;
	for (int i = 0; i <= N; i++)
		coef[i] = '0;
	for (int i = 1; i <= 2 * T; i++) begin
		e = i;
		repeat (M) begin
			inSet[e] = 1'b1;
			e = (2 * e) % N; // conjugate root
		end
	end
	coef[0] = gfElem'(1);
	deg = 0;
	root = gfElem'(1);
	for (int p = 0; p < N; p++) begin
		if (inSet[p]) begin
			deg++;
			for (int k = deg; k > 0; k--)
				coef[k] = coef[k-1] ^ fieldMul(root, coef[k]);
			coef[0] = fieldMul(root, coef[0]);
		end
		root = fieldMul(root, gfElem'(2)); // next power of alpha
	end
	for (int k = 0; k <= N; k++)
		gen[k] = coef[k][0]; // binary coefficients only
endtask

// systematic encoder, message in the high bits, first sent bit is bit N-1
function automatic logic [N-1:0] encode(input logic [N-1:0] msg, input logic [N:0] gen,
		input int deg);
	logic [N:0] work;
	work = (N + 1)'(msg) << deg;
	for (int i = N - 1; i >= deg; i--)
		if (work[i])
			work = work ^ (gen << (i - deg));
	return (msg << deg) | work[N-1:0];
endfunction

// error mask with count distinct random positions
task automatic randomErrors(inout integer seed, input int count, output logic [N-1:0] mask);
	int pos;
	mask = '0;
	while ($countones(mask) < count) begin
		pos = int'($unsigned($random(seed)) % N);
		mask[pos] = 1'b1;
	end
endtask

// T+1 errors that leave the word more than T flips away from every code word
task automatic detectableErrors(inout integer seed, input logic [N:0] gen, input int deg,
		output logic [N-1:0] mask);
	bit covered;
	covered = 1'b1;
	while (covered) begin
		randomErrors(seed, T + 1, mask);
		covered = 1'b0;
		for (int msg = 0; msg < (1 << (N - deg)); msg++)
			if ($countones(mask ^ encode(N'(msg), gen, deg)) <= T)
				covered = 1'b1;
	end
endtask

`endif

// ==== test/bchDecoderTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bchDecoderTb;
	import bchPkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int FRAMES = 20; // the reset test adds two flushed frames and one cut frame
	localparam int WATCHDOG_CYCLES = FRAMES * (N + 2 * T + 4) + 50;

	`include "bchModel.svh"

	logic clk;
	logic rst;
	logic dataIn;
	logic dataValid;
	logic dataFirst;
	wire logic ready;
	wire corrOut dutOut;

	integer seed;
	int cycle = 0;
	logic [N:0] genPoly;
	int genDeg;
	int bitErrors = 0;
	int failErrors = 0;
	int countErrors = 0;
	int otherErrors = 0;
	int framesOut = 0;
	int rxCount = 0;
	logic [N-1:0] rxWord;

	int lastIn[$]; // cycle of the last input bit of each full frame
	logic [N-1:0] expWord[$];
	logic expKnown[$]; // bits are checked only when known
	logic expFail[$];

	bchDecoder uut (
		.clk(clk),
		.rst(rst),
		.dataIn(dataIn),
		.dataValid(dataValid),
		.dataFirst(dataFirst),
		.ready(ready),
		.out(dutOut)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: decoder output did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	task automatic checkBit(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			bitErrors++;
			$display("[ERROR] %0t: %s expected %b got %b", $time, what, expected, actual);
		end
	endtask

	task automatic checkFail(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			failErrors++;
			$display("[ERROR] %0t: %s expected fail %b got %b", $time, what, expected, actual);
		end
	endtask

	task automatic checkCount(input int actual, input int expected, input string what);
		if (actual != expected) begin
			countErrors++;
			$display("[ERROR] %0t: %s expected %0d got %0d", $time, what, expected, actual);
		end
	endtask

	task automatic finishFrame();
		logic [N-1:0] word;
		logic known;
		checkCount(rxCount, N, "valid bits between first and last");
		if (expWord.size() == 0) begin
			otherErrors++;
			$display("decoder sent frame %0d that was never expected", framesOut);
		end else begin
			word = expWord.pop_front();
			known = expKnown.pop_front();
			if (known)
				for (int i = N - 1; i >= 0; i--)
					checkBit(rxWord[i], word[i],
						$sformatf("frame %0d bit %0d", framesOut, N - 1 - i));
			checkFail(dutOut.fail, expFail.pop_front(), $sformatf("frame %0d", framesOut));
		end
		framesOut++;
	endtask

	// output side is stable at the falling edge
	always @(negedge clk) begin
		if (rst) begin
			rxCount = 0;
		end else if (dutOut.valid) begin
			if (dutOut.first) begin
				rxCount = 0;
				if (lastIn.size() > 0)
					checkCount(cycle - lastIn.pop_front(), 2 * T + 3,
						"cycles from last input bit to first output bit");
				else begin
					otherErrors++;
					$display("decoder started an output frame with no frame sent");
				end
			end
			rxWord = {rxWord[N-2:0], dutOut.dataBit};
			rxCount++;
			if (dutOut.last)
				finishFrame();
		end
	end

	// starts on the first cycle that ready allows
	task automatic driveBits(input logic [N-1:0] word, input int count);
		while (!ready) begin
			@(posedge clk);
			#1;
		end
		for (int i = 0; i < count; i++) begin
			dataValid = 1'b1;
			dataFirst = (i == 0);
			dataIn = word[N-1-i];
			if (i == N - 1)
				lastIn.push_back(cycle);
			@(posedge clk);
			#1;
		end
		dataValid = 1'b0;
		dataFirst = 1'b0;
		dataIn = 1'b0;
	endtask

	task automatic sendFrame(input logic [N-1:0] word, input logic [N-1:0] errMask,
			input logic known, input logic failExp);
		expWord.push_back(word);
		expKnown.push_back(known);
		expFail.push_back(failExp);
		driveBits(word ^ errMask, N);
	endtask

	task automatic pickWord(output logic [N-1:0] word);
		word = encode(N'($unsigned($random(seed)) % (1 << (N - genDeg))), genPoly, genDeg);
	endtask

	task automatic waitForOutputs();
		while (expWord.size() > 0)
			@(negedge clk);
		@(posedge clk);
		#1;
	endtask

	// two clock edges with reset high, released by the caller
	task automatic holdReset();
		rst = 1'b1;
		repeat (2) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic cleanFrames();
		logic [N-1:0] word;
		repeat (3) begin
			pickWord(word);
			sendFrame(word, '0, 1'b1, 1'b0);
		end
	endtask

	task automatic correctableFrames();
		logic [N-1:0] word;
		logic [N-1:0] mask;
		for (int e = 1; e <= T; e++)
			repeat (2) begin
				pickWord(word);
				randomErrors(seed, e, mask);
				sendFrame(word, mask, 1'b1, 1'b0);
			end
	endtask

	task automatic uncorrectableFrames();
		logic [N-1:0] word;
		logic [N-1:0] mask;
		repeat (3) begin
			pickWord(word);
			detectableErrors(seed, genPoly, genDeg, mask);
			sendFrame(word, mask, 1'b0, 1'b1);
		end
	endtask

	task automatic backToBackFrames();
		logic [N-1:0] word;
		logic [N-1:0] mask;
		for (int f = 0; f < 4; f++) begin
			pickWord(word);
			randomErrors(seed, f % (T + 1), mask);
			sendFrame(word, mask, 1'b1, 1'b0);
		end
	endtask

	// one reset lands while the locator runs, another while a frame streams out
	// and the next is half in
	task automatic resetMidFrame();
		logic [N-1:0] word;
		logic [N-1:0] mask;
		waitForOutputs();
		pickWord(word);
		driveBits(word, N);
		checkBit(ready, 1'b0, "ready before reset");
		holdReset();
		checkBit(ready, 1'b1, "ready during reset");
		lastIn.delete();
		rst = 1'b0;
		pickWord(word);
		driveBits(word, N);
		pickWord(word);
		driveBits(word, N / 2);
		checkBit(dutOut.valid, 1'b1, "valid before reset");
		holdReset();
		checkBit(dutOut.valid, 1'b0, "valid during reset");
		lastIn.delete();
		rst = 1'b0;
		pickWord(word);
		randomErrors(seed, 2, mask);
		sendFrame(word, mask, 1'b1, 1'b0);
	endtask

	initial begin
		seed = 32'he061_ddca;
		rst = 1'b1;
		dataIn = 1'b0;
		dataValid = 1'b0;
		dataFirst = 1'b0;
		rxWord = '0;
		buildGenerator(genPoly, genDeg);
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		cleanFrames();
		correctableFrames();
		uncorrectableFrames();
		backToBackFrames();
		resetMidFrame();
		waitForOutputs();
		$display("errors: bit %0d, fail %0d, count %0d, other %0d (%0d frames out)",
			bitErrors, failErrors, countErrors, otherErrors, framesOut);
		if (bitErrors + failErrors + countErrors + otherErrors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end
endmodule

`default_nettype wire
